// File: logic/pd_format_pkg.sv
package pd_format_pkg;

    // fixed point layout of the sample stream
    localparam int FRAC_BITS = 15;             // q0.15 samples and q0.15 threshold
    localparam int SAMPLE_W  = 16;             // one i or q component
    localparam int MULT_W    = 2*SAMPLE_W + 1; // full complex product incl. sum bit

    // widths after each arithmetic step
    localparam int PROD_W    = 18;             // product after the >>> FRAC_BITS
    localparam int ACC_W     = 22;             // 16 products summed, 4 growth bits
    localparam int POWER_W   = 46;             // squared window sums
    localparam int SCALED_W  = 62;             // energy squared times threshold

    // one signed component, q0.15
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // complex sample as it sits on the lane bus
    typedef struct packed {
        sample_t re; // in phase
        sample_t im; // quadrature
    } cplx_sample_t;

    // unshifted sum of two 16x16 products
    typedef logic signed [MULT_W-1:0] mult_t;

    // scaled correlation or energy term of one sample
    typedef logic signed [PROD_W-1:0] prod_t;

    // sliding window sum of 16 prod_t values
    typedef logic signed [ACC_W-1:0] acc_t;

    // squared magnitude or shifted threshold term
    typedef logic signed [POWER_W-1:0] power_t;

    // energy squared times the q0.15 ratio, before the shift
    typedef logic signed [SCALED_W-1:0] scaled_t;

endpackage

// File: logic/pd_detect_pkg.sv
package pd_detect_pkg;

    // parallel lanes with one sample each per clock
    localparam int NUM_LANES = 16;

    // short preamble repeats every 16 samples
    localparam int PERIOD = 16; // correlation lag and window length

    // threshold ratio of about 0.7 in q0.15, 22986 / 2^15 is 0.7015
    localparam pd_format_pkg::sample_t DETECT_THRESH = 16'sd22986;

    // edges from samples_i to decision_o
    // products 1, window sums 1, decision 2
    localparam int PIPE_LATENCY = 4;

    // window sums of one lane handed from window_sum to lane_decision
    typedef struct packed {
        pd_format_pkg::acc_t corr_re; // sum of re(s * conj(d))
        pd_format_pkg::acc_t corr_im; // sum of im(s * conj(d))
        pd_format_pkg::acc_t energy;  // sum of |d|^2
    } lane_sums_t;

    // one decision bit per lane where bit k belongs to stream index 16n+k
    typedef logic [NUM_LANES-1:0] lane_vec_t;

endpackage

// File: logic/lane_products.sv
`timescale 1ns/10ps

module lane_products
    import pd_format_pkg::*;
    import pd_detect_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  cplx_sample_t [NUM_LANES-1:0] samples_i, // lane k holds s[16n+k]
    output prod_t        [NUM_LANES-1:0] corr_re_o, // re(s[m] * conj(s[m-16]))
    output prod_t        [NUM_LANES-1:0] corr_im_o, // im(s[m] * conj(s[m-16]))
    output prod_t        [NUM_LANES-1:0] energy_o   // |s[m-16]|^2
);

    // the last PERIOD samples of the previous clock
    cplx_sample_t [PERIOD-1:0]    delay_q;

    // full precision results, before scaling
    mult_t        [NUM_LANES-1:0] full_re;
    mult_t        [NUM_LANES-1:0] full_im;
    mult_t        [NUM_LANES-1:0] full_en;

    prod_t        [NUM_LANES-1:0] corr_re_q;
    prod_t        [NUM_LANES-1:0] corr_im_q;
    prod_t        [NUM_LANES-1:0] energy_q;

    // lag equals the lane count, so each lane pairs with itself one clock back
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            // (a + jb)(c - jd) = (ac + bd) + j(bc - ad)
            full_re[k] = samples_i[k].re * delay_q[k].re
                       + samples_i[k].im * delay_q[k].im;
            full_im[k] = samples_i[k].im * delay_q[k].re
                       - samples_i[k].re * delay_q[k].im;
            // delayed sample times its own conjugate, real only
            full_en[k] = delay_q[k].re * delay_q[k].re
                       + delay_q[k].im * delay_q[k].im;
        end
    end

    // delay line, keeps the newest PERIOD lanes of the vector
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            delay_q <= '0; // history before reset counts as zero
        end else begin
            for (int j = 0; j < PERIOD; j++) begin
                delay_q[j] <= samples_i[NUM_LANES-PERIOD+j];
            end
        end
    end

    // q1.30 back to q.15, fits 18 bits even for -1 * -1 twice
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            corr_re_q <= '0;
            corr_im_q <= '0;
            energy_q  <= '0;
        end else begin
            for (int k = 0; k < NUM_LANES; k++) begin
                corr_re_q[k] <= prod_t'(full_re[k] >>> FRAC_BITS); // arithmetic shift
                corr_im_q[k] <= prod_t'(full_im[k] >>> FRAC_BITS);
                energy_q[k]  <= prod_t'(full_en[k] >>> FRAC_BITS); // never negative
            end
        end
    end

    assign corr_re_o = corr_re_q;
    assign corr_im_o = corr_im_q;
    assign energy_o  = energy_q;

endmodule

// File: logic/window_sum.sv
`timescale 1ns/10ps

module window_sum
    import pd_format_pkg::*;
    import pd_detect_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  prod_t      [NUM_LANES-1:0] corr_re_i, // products of cycle n
    input  prod_t      [NUM_LANES-1:0] corr_im_i,
    input  prod_t      [NUM_LANES-1:0] energy_i,
    output lane_sums_t [NUM_LANES-1:0] sums_o     // window ending at 16n+k
);

    // products of cycle n-1, needed by windows that cross the boundary
    prod_t      [NUM_LANES-1:0] corr_re_q;
    prod_t      [NUM_LANES-1:0] corr_im_q;
    prod_t      [NUM_LANES-1:0] energy_q;

    lane_sums_t [NUM_LANES-1:0] sums_d;
    lane_sums_t [NUM_LANES-1:0] sums_q;

    // lanes 0..k come from this cycle, lanes k+1..15 from the held vector
    function automatic acc_t window_of(
        input prod_t [NUM_LANES-1:0] cur,
        input prod_t [NUM_LANES-1:0] held,
        input int                    lane
    );
        acc_t acc;
        acc = '0;
        for (int j = 0; j < NUM_LANES; j++) begin
            if (j <= lane) begin
                acc = acc + acc_t'(cur[j]);  // sign extended
            end else begin
                acc = acc + acc_t'(held[j]);
            end
        end
        return acc;
    endfunction

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            sums_d[k].corr_re = window_of(corr_re_i, corr_re_q, k);
            sums_d[k].corr_im = window_of(corr_im_i, corr_im_q, k);
            sums_d[k].energy  = window_of(energy_i, energy_q, k);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            corr_re_q <= '0; // empty window after reset
            corr_im_q <= '0;
            energy_q  <= '0;
            sums_q    <= '0;
        end else begin
            corr_re_q <= corr_re_i;
            corr_im_q <= corr_im_i;
            energy_q  <= energy_i;
            sums_q    <= sums_d;   // one clock from products to sums
        end
    end

    assign sums_o = sums_q;

endmodule

// File: logic/lane_decision.sv
`timescale 1ns/10ps

module lane_decision
    import pd_format_pkg::*;
    import pd_detect_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  lane_sums_t sums_i,   // window sums of this lane
    output logic       detect_o  // high while the window looks periodic
);

    // stage one inputs, combinational
    power_t  corr_sq;            // corr_re^2 + corr_im^2
    power_t  energy_sq;          // energy^2
    scaled_t scaled;             // energy^2 * ratio, still q.15 too wide
    power_t  thresh;             // scaled back to the corr_sq format

    // stage one registers
    power_t  corr_sq_q;
    power_t  thresh_q;

    // stage two
    logic    detect_q;

    always_comb begin
        // casts widen before the multiply so no bits are lost
        corr_sq   = power_t'(sums_i.corr_re) * power_t'(sums_i.corr_re)
                  + power_t'(sums_i.corr_im) * power_t'(sums_i.corr_im);
        energy_sq = power_t'(sums_i.energy) * power_t'(sums_i.energy);
        scaled    = scaled_t'(energy_sq) * scaled_t'(DETECT_THRESH);
        // drop the fraction bits of the ratio, at most about 2^40 remains
        thresh    = power_t'(scaled >>> FRAC_BITS);
    end

    // |corr|^2 and 0.7 * energy^2 side by side
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            corr_sq_q <= '0;
            thresh_q  <= '0;
        end else begin
            corr_sq_q <= corr_sq;
            thresh_q  <= thresh;
        end
    end

    // a zero threshold means no energy in the window, so no packet
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            detect_q <= 1'b0;
        end else begin
            detect_q <= (corr_sq_q > thresh_q) && (thresh_q != '0);
        end
    end

    assign detect_o = detect_q; // registered level, valid every cycle

endmodule

// File: logic/packet_detector.sv
`timescale 1ns/10ps

module packet_detector
    import pd_format_pkg::*;
    import pd_detect_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  cplx_sample_t [NUM_LANES-1:0] samples_i,  // new vector every clock
    output lane_vec_t                    decision_o  // PIPE_LATENCY edges later
);

    // per lane products, one clock after the samples
    prod_t      [NUM_LANES-1:0] corr_re;
    prod_t      [NUM_LANES-1:0] corr_im;
    prod_t      [NUM_LANES-1:0] energy;

    // per lane window sums, two clocks after the samples
    lane_sums_t [NUM_LANES-1:0] sums;

    lane_products u_products (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .samples_i (samples_i),
        .corr_re_o (corr_re),
        .corr_im_o (corr_im),
        .energy_o  (energy)
    );

    window_sum u_window (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .corr_re_i (corr_re),
        .corr_im_i (corr_im),
        .energy_i  (energy),
        .sums_o    (sums)
    );

    // one decider per lane, two more clocks each
    for (genvar k = 0; k < NUM_LANES; k++) begin : lane_gen
        lane_decision u_decision (
            .clk_i    (clk_i),
            .rst_i    (rst_i),
            .sums_i   (sums[k]),
            .detect_o (decision_o[k])  // bit k is stream index 16n+k
        );
    end

endmodule

// File: verification/pd_checker.sv
`timescale 1ns/10ps

module pd_checker
    import pd_format_pkg::*;
    import pd_detect_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  cplx_sample_t [NUM_LANES-1:0] samples_i,        // same vector the DUT sees
    input  lane_vec_t                    decision_i,       // DUT decision_o
    output int                           mismatch_count_o,
    output int                           checked_count_o
);

    longint    hist_re [PERIOD];  // s[m-16] .. s[m-1], oldest first
    longint    hist_im [PERIOD];
    longint    win_re  [PERIOD];  // last 16 correlation products
    longint    win_im  [PERIOD];
    longint    win_en  [PERIOD];  // last 16 energies
    lane_vec_t expect_q [$];      // expected vectors still in the pipeline
    bit        armed = 1'b0;      // set by the first reset edge
    int        mismatches = 0;
    int        checked = 0;

    task automatic clear_model();
        for (int j = 0; j < PERIOD; j++) begin
            hist_re[j] = 0;
            hist_im[j] = 0;
            win_re[j]  = 0;
            win_im[j]  = 0;
            win_en[j]  = 0;
        end
        expect_q.delete();
        repeat (PIPE_LATENCY) expect_q.push_back('0); // reset zeros still in flight
    endtask

    // one stream sample in, one decision bit out
    task automatic model_sample(input longint s_re, input longint s_im, output bit hit);
        longint d_re;
        longint d_im;
        longint p_re;
        longint p_im;
        longint p_en;
        longint c_re;
        longint c_im;
        longint c_en;
        longint mag;
        longint lim;
        d_re = hist_re[0];                                   // sample 16 positions back
        d_im = hist_im[0];
        p_re = (s_re * d_re + s_im * d_im) >>> FRAC_BITS;   // s * conj(d)
        p_im = (s_im * d_re - s_re * d_im) >>> FRAC_BITS;
        p_en = (d_re * d_re + d_im * d_im) >>> FRAC_BITS;   // |d|^2
        for (int j = 0; j < PERIOD - 1; j++) begin
            hist_re[j] = hist_re[j+1];
            hist_im[j] = hist_im[j+1];
            win_re[j]  = win_re[j+1];
            win_im[j]  = win_im[j+1];
            win_en[j]  = win_en[j+1];
        end
        hist_re[PERIOD-1] = s_re;
        hist_im[PERIOD-1] = s_im;
        win_re[PERIOD-1]  = p_re;
        win_im[PERIOD-1]  = p_im;
        win_en[PERIOD-1]  = p_en;
        c_re = 0;
        c_im = 0;
        c_en = 0;
        for (int j = 0; j < PERIOD; j++) begin
            c_re += win_re[j];   // window m-15 .. m
            c_im += win_im[j];
            c_en += win_en[j];
        end
        mag = c_re * c_re + c_im * c_im;
        lim = (c_en * c_en * DETECT_THRESH) >>> FRAC_BITS;  // 0.7 * energy^2
        hit = (mag > lim) && (lim != 0);
    endtask

    // inputs are stable at the edge, driven 1 ns after the previous one
    always @(posedge clk_i) begin : model_step
        lane_vec_t exp_vec;
        bit        hit;
        if (rst_i) begin
            clear_model();
            armed = 1'b1;
        end else if (armed) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                model_sample(samples_i[k].re, samples_i[k].im, hit); // lane k is index 16n+k
                exp_vec[k] = hit;
            end
            expect_q.push_back(exp_vec);
            void'(expect_q.pop_front()); // keep PIPE_LATENCY entries
        end
    end

    // compare mid cycle, well away from the edge
    always @(negedge clk_i) begin
        if (armed && expect_q.size() == PIPE_LATENCY) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                if (decision_i[k] !== expect_q[0][k]) begin
                    $display("Mismatch at time %0t: lane %0d expected %0b got %0b",
                             $time, k, expect_q[0][k], decision_i[k]);
                    mismatches++;
                end
            end
            checked++;
        end
    end

    assign mismatch_count_o = mismatches;
    assign checked_count_o  = checked;

endmodule

// File: verification/tb_packet_detector.sv
`timescale 1ns/10ps

module tb_packet_detector
    import pd_format_pkg::*;
    import pd_detect_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int WAIT_LIMIT   = 20;  // cycles before a wait gives up

    logic                         clk_i;
    logic                         rst_i;
    cplx_sample_t [NUM_LANES-1:0] samples_i;
    lane_vec_t                    decision_o;

    int  mismatch_count;
    int  checked_count;
    int  check_errors = 0;   // preamble and drain check failures
    int  ones_seen;          // cycles with every lane detecting
    bit  timed_out = 1'b0;
    cplx_sample_t [NUM_LANES-1:0] base_vec;

    always #4 clk_i = ~clk_i; // 8 ns period

    packet_detector uut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .samples_i  (samples_i),
        .decision_o (decision_o)
    );

    pd_checker checker_inst (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .samples_i        (samples_i),
        .decision_i       (decision_o),
        .mismatch_count_o (mismatch_count),
        .checked_count_o  (checked_count)
    );

    task automatic next_cycle();
        @(posedge clk_i);
        #1; // drive away from the edge
    endtask

    // rst_i high for RESET_CYCLES rising edges
    task automatic apply_reset();
        rst_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
    endtask

    task automatic wait_checked(input int target, input string what);
        for (int i = 0; i < WAIT_LIMIT && checked_count < target; i++) begin
            @(posedge clk_i);
        end
        if (checked_count < target) begin
            $display("Timeout while waiting for %s", what);
            timed_out = 1'b1;
        end
    endtask

    task automatic drive_noise(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            next_cycle();
            for (int k = 0; k < NUM_LANES; k++) begin
                samples_i[k] = cplx_sample_t'($urandom()); // full range re and im
            end
        end
    endtask

    // same vector every cycle makes the stream repeat every 16 samples
    task automatic drive_vector(input cplx_sample_t [NUM_LANES-1:0] vec, input int cycles);
        ones_seen = 0;
        for (int c = 0; c < cycles; c++) begin
            next_cycle();
            samples_i = vec;
            if (decision_o == '1) ones_seen++;
        end
    endtask

    function automatic sample_t loud_value();
        int mag;
        mag = int'($urandom_range(32767, 16384)); // at least half scale
        if ($urandom() & 1) mag = -mag;
        return sample_t'(mag);
    endfunction

    task automatic make_preamble();
        for (int k = 0; k < NUM_LANES; k++) begin
            base_vec[k].re = loud_value();
            base_vec[k].im = loud_value();
        end
    endtask

    initial begin
        int unused_seed;
        clk_i     = 1'b0;
        rst_i     = 1'b1;
        samples_i = '0;
        unused_seed = $urandom(32'hd397_a55f);
        apply_reset();
        wait_checked(checked_count + PIPE_LATENCY, "decisions after reset release");
        if (!timed_out) begin
            drive_noise(400);
            drive_vector('0, 50);                  // windows drain to zero
            if (decision_o != '0) begin
                $display("Mismatch at time %0t: decisions %h after all-zero input",
                         $time, decision_o);
                check_errors++;
            end
            make_preamble();
            drive_vector(base_vec, 200);
            if (ones_seen < 190) begin
                $display("Preamble gave all lanes high in only %0d of 200 cycles", ones_seen);
                check_errors++;
            end
            make_preamble();
            drive_vector(base_vec, 100);
            apply_reset();                         // cut into the burst
            wait_checked(checked_count + PIPE_LATENCY, "decisions after mid-burst reset");
        end
        if (!timed_out) begin
            drive_vector(base_vec, 100);
            wait_checked(checked_count + PIPE_LATENCY, "the pipeline to drain");
        end
        $display("Errors: %0d mismatches, %0d other, %0d vectors checked, timeout %0b",
                 mismatch_count, check_errors, checked_count, timed_out);
        if (timed_out || mismatch_count != 0 || check_errors != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/pd_format_pkg.sv
logic/pd_detect_pkg.sv
logic/lane_products.sv
logic/window_sum.sv
logic/lane_decision.sv
logic/packet_detector.sv
verification/pd_checker.sv
verification/tb_packet_detector.sv

// File: Bender.yml
package:
  name: packet_detector

sources:
  - files:
      - logic/pd_format_pkg.sv
      - logic/pd_detect_pkg.sv
      - logic/lane_products.sv
      - logic/window_sum.sv
      - logic/lane_decision.sv
      - logic/packet_detector.sv
  - target: simulation
    files:
      - verification/pd_checker.sv
      - verification/tb_packet_detector.sv
